// File: Makefile
TOP := cm_rx_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(wildcard src/*.sv src/*.svh verif/*.sv)
	verilator --binary --assert --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qxF '*** PASSED ***'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

// File: list.f
+incdir+src
src/cm_udp_pkg.sv
src/cm_qp_pkg.sv
src/cm_beat_if.sv
src/cm_rx_ctrl.sv
src/cm_record_assembler.sv
src/cm_field_decoder.sv
src/udp_roce_cm_rx.sv
verif/cm_rx_tb.sv

// File: src/cm_beat_if.sv
interface cm_beat_if
    import cm_udp_pkg::*;
();

    beat_data_t data;
    beat_keep_t keep;
    logic       last;
    // Beat taken for a frame that passed the header checks
    logic       accept;
    // Beat taken for a frame being discarded
    logic       drain;

    modport ctrl (
        output data,
        output keep,
        output last,
        output accept,
        output drain
    );

    modport asm (
        input data,
        input keep,
        input last,
        input accept,
        input drain
    );

endinterface

// File: src/cm_field_decoder.sv
`include "cm_rx_macros.svh"

module cm_field_decoder
    import cm_qp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       rec_valid,
    input  cm_record_t rec,

    output qp_info_t   qp_info,
    output logic       qp_info_valid,
    output logic       qp_ack_valid,

    output txmeta_t    txmeta,
    output logic       metadata_valid,
    output logic       start_transfer
);

    qp_info_t qp_next;
    txmeta_t  tx_next;

    // Unpack the record into the two output groups
    always_comb begin
        qp_next.req_type       = rec.req_type;
        qp_next.ack_valid      = rec.ack_valid;
        qp_next.ack_type       = rec.ack_type;
        qp_next.loc_qpn        = rec.loc_qpn;
        qp_next.loc_psn        = rec.loc_psn;
        qp_next.loc_r_key      = rec.loc_r_key;
        qp_next.loc_base_addr  = rec.loc_base_addr;
        qp_next.loc_ip_addr    = rec.loc_ip_addr;
        qp_next.rem_qpn        = rec.rem_qpn;
        qp_next.rem_psn        = rec.rem_psn;
        qp_next.rem_r_key      = rec.rem_r_key;
        qp_next.rem_base_addr  = rec.rem_base_addr;
        qp_next.rem_ip_addr    = rec.rem_ip_addr;
        qp_next.listening_port = rec.listening_port;

        tx_next.start          = rec.start;
        tx_next.is_immediate   = rec.is_immediate;
        tx_next.tx_type        = rec.tx_type;
        // Transfers target the remote side of the queue pair
        tx_next.loc_qpn        = rec.rem_qpn;
        tx_next.dma_length     = rec.dma_length & `CM_DMA_ALIGN_MASK;
        tx_next.n_transfers    = rec.n_transfers;
        tx_next.frequency      = rec.frequency;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            qp_info_valid  <= 1'b0;
            metadata_valid <= 1'b0;
        end else begin
            qp_info_valid  <= rec_valid && rec.qp_valid;
            metadata_valid <= rec_valid && rec.txmeta_valid;
        end
    end

    // Each group holds until a record with its own valid bit arrives
    always_ff @(posedge clk) begin
        if (rec_valid && rec.qp_valid) begin
            qp_info <= qp_next;
        end
        if (rec_valid && rec.txmeta_valid) begin
            txmeta <= tx_next;
        end
    end

    assign qp_ack_valid   = qp_info_valid && qp_info.ack_valid;
    assign start_transfer = metadata_valid && txmeta.start;

    // One record in flight, so every valid pulse lasts a single cycle
    a_valid_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        (qp_info_valid || metadata_valid) |=> !(qp_info_valid || metadata_valid)
    );

endmodule

// File: src/cm_qp_pkg.sv
package cm_qp_pkg;

    typedef logic [23:0] qpn_t;
    typedef logic [23:0] psn_t;
    typedef logic [31:0] rkey_t;
    typedef logic [63:0] vaddr_t;
    typedef logic [31:0] ipv4_t;

    // Record as it sits in the payload, byte 63 on top and byte 0 at the bottom
    typedef struct packed {
        logic [31:0] frequency;
        logic [31:0] n_transfers;
        logic [31:0] dma_length;
        logic [3:0]  tx_rsvd;
        logic        tx_type;
        logic        is_immediate;
        logic        start;
        logic        txmeta_valid;
        logic [15:0] listening_port;
        ipv4_t       rem_ip_addr;
        vaddr_t      rem_base_addr;
        rkey_t       rem_r_key;
        logic [7:0]  pad_32;
        psn_t        rem_psn;
        logic [7:0]  pad_28;
        qpn_t        rem_qpn;
        ipv4_t       loc_ip_addr;
        vaddr_t      loc_base_addr;
        rkey_t       loc_r_key;
        logic [7:0]  pad_8;
        psn_t        loc_psn;
        logic [7:0]  pad_4;
        qpn_t        loc_qpn;
        logic [2:0]  ack_type;
        logic        ack_valid;
        logic [2:0]  req_type;
        logic        qp_valid;
    } cm_record_t;

    typedef struct packed {
        logic [2:0]  req_type;
        logic        ack_valid;
        logic [2:0]  ack_type;
        qpn_t        loc_qpn;
        psn_t        loc_psn;
        rkey_t       loc_r_key;
        vaddr_t      loc_base_addr;
        ipv4_t       loc_ip_addr;
        qpn_t        rem_qpn;
        psn_t        rem_psn;
        rkey_t       rem_r_key;
        vaddr_t      rem_base_addr;
        ipv4_t       rem_ip_addr;
        logic [15:0] listening_port;
    } qp_info_t;

    // tx_type 0 is SEND, 1 is RDMA WRITE
    typedef struct packed {
        logic        start;
        logic        is_immediate;
        logic        tx_type;
        qpn_t        loc_qpn;
        logic [31:0] dma_length;
        logic [31:0] n_transfers;
        logic [31:0] frequency;
    } txmeta_t;

endpackage

// File: src/cm_record_assembler.sv
`include "cm_rx_macros.svh"

module cm_record_assembler
    import cm_udp_pkg::*;
    import cm_qp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    cm_beat_if.asm     beat,

    output logic       rec_valid,
    output cm_record_t rec
);

    localparam beat_ptr_t LAST_PTR  = beat_ptr_t'(`CM_RECORD_BEATS - 1);
    localparam int        LAST_LANE = (`CM_RECORD_BYTES - 1) % `CM_KEEP_WIDTH;

    beat_ptr_t                       ptr;
    // Set when a beat arrives past the record without tlast
    logic                            overrun;
    logic [`CM_RECORD_BYTES*8-1:0]   rec_bytes;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr       <= '0;
            overrun   <= 1'b0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            if (beat.accept) begin
                if (beat.last) begin
                    ptr     <= '0;
                    overrun <= 1'b0;
                    // Complete only when the final beat carries byte 63
                    rec_valid <= !overrun && (ptr == LAST_PTR) && beat.keep[LAST_LANE];
                end else if (ptr == LAST_PTR) begin
                    overrun <= 1'b1;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end else if (beat.drain) begin
                ptr     <= '0;
                overrun <= 1'b0;
            end
        end
    end

    // Only keep enabled byte lanes are written into the record
    always_ff @(posedge clk) begin
        int idx;
        if (beat.accept) begin
            for (int i = 0; i < `CM_KEEP_WIDTH; i++) begin
                idx = int'(ptr) * `CM_KEEP_WIDTH + i;
                if (beat.keep[i] && idx < `CM_RECORD_BYTES) begin
                    rec_bytes[idx*8 +: 8] <= beat.data[i*8 +: 8];
                end
            end
        end
    end

    assign rec = cm_record_t'(rec_bytes);

    // A drained frame only starts once the previous frame has closed
    a_ptr_clear_on_drain: assert property (
        @(posedge clk) disable iff (rst) beat.drain |-> ptr == '0
    );

    // Controller never marks a beat both taken and discarded
    a_accept_drain_excl: assert property (
        @(posedge clk) disable iff (rst) !(beat.accept && beat.drain)
    );

endmodule

// File: src/cm_rx_ctrl.sv
`include "cm_rx_macros.svh"

module cm_rx_ctrl
    import cm_udp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       hdr_valid,
    output logic       hdr_ready,
    input  udp_port_t  udp_dest_port,
    input  udp_len_t   udp_length,

    input  beat_data_t payload_tdata,
    input  beat_keep_t payload_tkeep,
    input  logic       payload_tvalid,
    output logic       payload_tready,
    input  logic       payload_tlast,

    output logic       busy,

    cm_beat_if.ctrl    beat
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RECV,
        ST_DRAIN
    } state_t;

    state_t state;
    logic   hdr_fire;
    logic   beat_fire;
    logic   hdr_match;

    assign hdr_fire  = hdr_valid && hdr_ready;
    assign beat_fire = payload_tvalid && payload_tready;

    // Only our port with exactly one record behind the UDP header is taken
    assign hdr_match = (udp_dest_port == udp_port_t'(`CM_LISTEN_PORT))
                    && (udp_length == udp_len_t'(`CM_UDP_HDR_BYTES + `CM_RECORD_BYTES));

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            hdr_ready      <= 1'b0;
            payload_tready <= 1'b0;
            busy           <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    hdr_ready <= 1'b1;
                    if (hdr_fire) begin
                        // Failing frames are still read out so the source never stalls
                        state          <= hdr_match ? ST_RECV : ST_DRAIN;
                        hdr_ready      <= 1'b0;
                        payload_tready <= 1'b1;
                        busy           <= 1'b1;
                    end
                end
                ST_RECV, ST_DRAIN: begin
                    if (beat_fire && payload_tlast) begin
                        state          <= ST_IDLE;
                        hdr_ready      <= 1'b1;
                        payload_tready <= 1'b0;
                        busy           <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Beats to the assembler
    assign beat.data   = payload_tdata;
    assign beat.keep   = payload_tkeep;
    assign beat.last   = payload_tlast;
    assign beat.accept = beat_fire && (state == ST_RECV);
    assign beat.drain  = beat_fire && (state == ST_DRAIN);

    // Header and payload phases never overlap
    a_ready_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(hdr_ready && payload_tready)
    );

endmodule

// File: src/cm_rx_macros.svh
`ifndef CM_RX_MACROS_SVH
`define CM_RX_MACROS_SVH

// Payload beat width and byte lanes per beat
`define CM_DATA_WIDTH 256
`define CM_KEEP_WIDTH (`CM_DATA_WIDTH / 8)

// Connection record carried in the UDP payload
`define CM_RECORD_BYTES 64
`define CM_UDP_HDR_BYTES 8

// Port the connection manager listens on
`define CM_LISTEN_PORT 16'h4321

// Beats needed to carry one record, rounded up
`define CM_RECORD_BEATS ((`CM_RECORD_BYTES + `CM_KEEP_WIDTH - 1) / `CM_KEEP_WIDTH)

// DMA length is kept a multiple of 4 bytes
`define CM_DMA_ALIGN_MASK 32'hFFFF_FFFC

`endif

// File: src/cm_udp_pkg.sv
`include "cm_rx_macros.svh"

package cm_udp_pkg;

    // UDP header fields
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // One payload beat
    typedef logic [`CM_DATA_WIDTH-1:0] beat_data_t;
    typedef logic [`CM_KEEP_WIDTH-1:0] beat_keep_t;

    // Beat index within a record, at least one bit even for single-beat records
    localparam int BEAT_PTR_W = (`CM_RECORD_BEATS > 1) ? $clog2(`CM_RECORD_BEATS) : 1;

    typedef logic [BEAT_PTR_W-1:0] beat_ptr_t;

endpackage

// File: src/udp_roce_cm_rx.sv
module udp_roce_cm_rx
    import cm_udp_pkg::*;
    import cm_qp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // UDP header
    input  logic        hdr_valid,
    output logic        hdr_ready,
    input  udp_port_t   udp_dest_port,
    input  udp_len_t    udp_length,

    // UDP payload
    input  beat_data_t  payload_tdata,
    input  beat_keep_t  payload_tkeep,
    input  logic        payload_tvalid,
    output logic        payload_tready,
    input  logic        payload_tlast,

    // Queue pair connection info
    output logic        qp_info_valid,
    output logic        qp_ack_valid,
    output logic [2:0]  qp_info_req_type,
    output logic        qp_info_ack_valid,
    output logic [2:0]  qp_info_ack_type,
    output qpn_t        qp_info_loc_qpn,
    output psn_t        qp_info_loc_psn,
    output rkey_t       qp_info_loc_r_key,
    output vaddr_t      qp_info_loc_base_addr,
    output ipv4_t       qp_info_loc_ip_addr,
    output qpn_t        qp_info_rem_qpn,
    output psn_t        qp_info_rem_psn,
    output rkey_t       qp_info_rem_r_key,
    output vaddr_t      qp_info_rem_base_addr,
    output ipv4_t       qp_info_rem_ip_addr,
    output logic [15:0] qp_info_listening_port,

    // Transmit metadata
    output logic        metadata_valid,
    output logic        start_transfer,
    output logic        txmeta_start,
    output logic        txmeta_is_immediate,
    output logic        txmeta_tx_type,
    output qpn_t        txmeta_loc_qpn,
    output logic [31:0] txmeta_dma_length,
    output logic [31:0] txmeta_n_transfers,
    output logic [31:0] txmeta_frequency,

    output logic        busy
);

    cm_beat_if  beat_bus ();
    logic       rec_valid;
    cm_record_t rec;
    qp_info_t   qp_info;
    txmeta_t    txmeta;

    cm_rx_ctrl cm_rx_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .udp_dest_port  (udp_dest_port),
        .udp_length     (udp_length),
        .payload_tdata  (payload_tdata),
        .payload_tkeep  (payload_tkeep),
        .payload_tvalid (payload_tvalid),
        .payload_tready (payload_tready),
        .payload_tlast  (payload_tlast),
        .busy           (busy),
        .beat           (beat_bus.ctrl)
    );

    cm_record_assembler cm_record_assembler_inst (
        .clk       (clk),
        .rst       (rst),
        .beat      (beat_bus.asm),
        .rec_valid (rec_valid),
        .rec       (rec)
    );

    cm_field_decoder cm_field_decoder_inst (
        .clk            (clk),
        .rst            (rst),
        .rec_valid      (rec_valid),
        .rec            (rec),
        .qp_info        (qp_info),
        .qp_info_valid  (qp_info_valid),
        .qp_ack_valid   (qp_ack_valid),
        .txmeta         (txmeta),
        .metadata_valid (metadata_valid),
        .start_transfer (start_transfer)
    );

    assign qp_info_req_type       = qp_info.req_type;
    assign qp_info_ack_valid      = qp_info.ack_valid;
    assign qp_info_ack_type       = qp_info.ack_type;
    assign qp_info_loc_qpn        = qp_info.loc_qpn;
    assign qp_info_loc_psn        = qp_info.loc_psn;
    assign qp_info_loc_r_key      = qp_info.loc_r_key;
    assign qp_info_loc_base_addr  = qp_info.loc_base_addr;
    assign qp_info_loc_ip_addr    = qp_info.loc_ip_addr;
    assign qp_info_rem_qpn        = qp_info.rem_qpn;
    assign qp_info_rem_psn        = qp_info.rem_psn;
    assign qp_info_rem_r_key      = qp_info.rem_r_key;
    assign qp_info_rem_base_addr  = qp_info.rem_base_addr;
    assign qp_info_rem_ip_addr    = qp_info.rem_ip_addr;
    assign qp_info_listening_port = qp_info.listening_port;

    assign txmeta_start           = txmeta.start;
    assign txmeta_is_immediate    = txmeta.is_immediate;
    assign txmeta_tx_type         = txmeta.tx_type;
    assign txmeta_loc_qpn         = txmeta.loc_qpn;
    assign txmeta_dma_length      = txmeta.dma_length;
    assign txmeta_n_transfers     = txmeta.n_transfers;
    assign txmeta_frequency       = txmeta.frequency;

endmodule

// File: verif/cm_rx_tb.sv
`include "cm_rx_macros.svh"

module cm_rx_tb
    import cm_udp_pkg::*;
    import cm_qp_pkg::*;
();

    localparam int       TIMEOUT  = 200;
    localparam int       BEAT_W   = `CM_DATA_WIDTH;
    localparam udp_len_t GOOD_LEN = udp_len_t'(`CM_UDP_HDR_BYTES + `CM_RECORD_BYTES);

    logic          clk = 1'b0;
    logic          rst;
    logic          hdr_valid;
    logic          hdr_ready;
    udp_port_t     udp_dest_port;
    udp_len_t      udp_length;
    beat_data_t    payload_tdata;
    beat_keep_t    payload_tkeep;
    logic          payload_tvalid;
    logic          payload_tready;
    logic          payload_tlast;
    logic          busy;
    logic          qp_info_valid;
    logic          qp_ack_valid;
    logic          metadata_valid;
    logic          start_transfer;
    wire qp_info_t qp_act;
    wire txmeta_t  meta_act;

    // Pulse counters for qp_info_valid, qp_ack_valid, metadata_valid, start_transfer
    int    pulse_cnt[4] = '{0, 0, 0, 0};
    string pulse_name[4] = '{"qp_info_valid", "qp_ack_valid", "metadata_valid", "start_transfer"};
    int    errors = 0;
    int    busy_err = 0;
    int    tests_run = 0;

    // Fields of the record being sent
    qp_info_t    gen_qp;
    logic        gen_qp_v, gen_tx_v, gen_start, gen_imm, gen_type;
    logic [31:0] gen_dma, gen_n, gen_freq;

    // Values the DUT outputs should be holding
    qp_info_t exp_qp;
    txmeta_t  exp_meta;

    udp_roce_cm_rx udp_roce_cm_rx_inst (
        .qp_info_req_type       (qp_act.req_type),
        .qp_info_ack_valid      (qp_act.ack_valid),
        .qp_info_ack_type       (qp_act.ack_type),
        .qp_info_loc_qpn        (qp_act.loc_qpn),
        .qp_info_loc_psn        (qp_act.loc_psn),
        .qp_info_loc_r_key      (qp_act.loc_r_key),
        .qp_info_loc_base_addr  (qp_act.loc_base_addr),
        .qp_info_loc_ip_addr    (qp_act.loc_ip_addr),
        .qp_info_rem_qpn        (qp_act.rem_qpn),
        .qp_info_rem_psn        (qp_act.rem_psn),
        .qp_info_rem_r_key      (qp_act.rem_r_key),
        .qp_info_rem_base_addr  (qp_act.rem_base_addr),
        .qp_info_rem_ip_addr    (qp_act.rem_ip_addr),
        .qp_info_listening_port (qp_act.listening_port),
        .txmeta_start           (meta_act.start),
        .txmeta_is_immediate    (meta_act.is_immediate),
        .txmeta_tx_type         (meta_act.tx_type),
        .txmeta_loc_qpn         (meta_act.loc_qpn),
        .txmeta_dma_length      (meta_act.dma_length),
        .txmeta_n_transfers     (meta_act.n_transfers),
        .txmeta_frequency       (meta_act.frequency),
        .*
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (qp_info_valid) pulse_cnt[0] <= pulse_cnt[0] + 1;
        if (qp_ack_valid) pulse_cnt[1] <= pulse_cnt[1] + 1;
        if (metadata_valid) pulse_cnt[2] <= pulse_cnt[2] + 1;
        if (start_transfer) pulse_cnt[3] <= pulse_cnt[3] + 1;
    end

    function automatic void randomize_fields();
        gen_qp.req_type       = 3'($urandom);
        gen_qp.ack_valid      = 1'($urandom);
        gen_qp.ack_type       = 3'($urandom);
        gen_qp.loc_qpn        = 24'($urandom);
        gen_qp.loc_psn        = 24'($urandom);
        gen_qp.loc_r_key      = $urandom;
        gen_qp.loc_base_addr  = {$urandom, $urandom};
        gen_qp.loc_ip_addr    = $urandom;
        gen_qp.rem_qpn        = 24'($urandom);
        gen_qp.rem_psn        = 24'($urandom);
        gen_qp.rem_r_key      = $urandom;
        gen_qp.rem_base_addr  = {$urandom, $urandom};
        gen_qp.rem_ip_addr    = $urandom;
        gen_qp.listening_port = 16'($urandom);
        gen_dma   = $urandom;
        gen_n     = $urandom;
        gen_freq  = $urandom;
        gen_start = 1'($urandom);
        gen_imm   = 1'($urandom);
        gen_type  = 1'($urandom);
        gen_qp_v  = 1'b1;
        gen_tx_v  = 1'b1;
    endfunction

    // Byte map of the record, little-endian fields, padding left at zero
    function automatic logic [511:0] build_record();
        logic [511:0] r;
        r = '0;
        r[7:0]       = {gen_qp.ack_type, gen_qp.ack_valid, gen_qp.req_type, gen_qp_v};
        r[1*8 +: 24]  = gen_qp.loc_qpn;
        r[5*8 +: 24]  = gen_qp.loc_psn;
        r[9*8 +: 32]  = gen_qp.loc_r_key;
        r[13*8 +: 64] = gen_qp.loc_base_addr;
        r[21*8 +: 32] = gen_qp.loc_ip_addr;
        r[25*8 +: 24] = gen_qp.rem_qpn;
        r[29*8 +: 24] = gen_qp.rem_psn;
        r[33*8 +: 32] = gen_qp.rem_r_key;
        r[37*8 +: 64] = gen_qp.rem_base_addr;
        r[45*8 +: 32] = gen_qp.rem_ip_addr;
        r[49*8 +: 16] = gen_qp.listening_port;
        r[51*8 +: 8]  = {4'b0000, gen_type, gen_imm, gen_start, gen_tx_v};
        r[52*8 +: 32] = gen_dma;
        r[56*8 +: 32] = gen_n;
        r[60*8 +: 32] = gen_freq;
        return r;
    endfunction

    function automatic txmeta_t expected_meta();
        txmeta_t m;
        m.start        = gen_start;
        m.is_immediate = gen_imm;
        m.tx_type      = gen_type;
        // Metadata QPN is the remote one
        m.loc_qpn      = gen_qp.rem_qpn;
        m.dma_length   = gen_dma & ~32'd3;
        m.n_transfers  = gen_n;
        m.frequency    = gen_freq;
        return m;
    endfunction

    task automatic check_qp(input string name, input qp_info_t exp, input qp_info_t act);
        if (act !== exp) begin
            $display("** Error %s: qp_info expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_meta(input string name, input txmeta_t exp, input txmeta_t act);
        if (act !== exp) begin
            $display("** Error %s: txmeta expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            $display("** Error %s: expected %0b actual %0b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_frame(input string name, input udp_port_t port, input udp_len_t len,
                              input logic [511:0] rec, input int nbeats, input int max_idle);
        int n;
        int idle;
        hdr_valid     <= 1'b1;
        udp_dest_port <= port;
        udp_length    <= len;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!hdr_ready && n < TIMEOUT);
        hdr_valid <= 1'b0;
        if (!hdr_ready) begin
            $display("%s: header was never accepted", name);
            errors++;
            return;
        end
        for (int b = 0; b < nbeats; b++) begin
            idle = (max_idle > 0) ? $urandom_range(max_idle, 0) : 0;
            if (idle > 0) payload_tvalid <= 1'b0;
            repeat (idle) begin
                @(posedge clk);
                if (!busy) busy_err++;
            end
            payload_tdata  <= rec[b*BEAT_W +: BEAT_W];
            payload_tkeep  <= '1;
            payload_tlast  <= (b == nbeats - 1);
            payload_tvalid <= 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
                if (!busy) busy_err++;
            end while (!payload_tready && n < TIMEOUT);
            if (!payload_tready) begin
                $display("%s: payload beat %0d was never accepted", name, b);
                errors++;
            end
        end
        payload_tvalid <= 1'b0;
        payload_tlast  <= 1'b0;
    endtask

    // Sends the current fields; good says whether the frame should be decoded
    task automatic send_and_check(input string name, input udp_port_t port, input udp_len_t len,
                                  input int nbeats, input int max_idle, input bit good);
        int base[4];
        int want[4];
        int busy0;
        int n;
        base  = pulse_cnt;
        busy0 = busy_err;
        want[0] = (good && gen_qp_v) ? 1 : 0;
        want[1] = (good && gen_qp_v && gen_qp.ack_valid) ? 1 : 0;
        want[2] = (good && gen_tx_v) ? 1 : 0;
        want[3] = (good && gen_tx_v && gen_start) ? 1 : 0;
        send_frame(name, port, len, build_record(), nbeats, max_idle);
        if (want[0] != 0) exp_qp = gen_qp;
        if (want[2] != 0) exp_meta = expected_meta();
        n = 0;
        while ((pulse_cnt[0] - base[0] < want[0] || pulse_cnt[2] - base[2] < want[2])
               && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            $display("%s: no valid pulse after the frame", name);
            errors++;
        end
        // Room for a second, unwanted pulse
        repeat (5) @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            check_count($sformatf("%s %s", name, pulse_name[i]), want[i], pulse_cnt[i] - base[i]);
        end
        check_qp(name, exp_qp, qp_act);
        check_meta(name, exp_meta, meta_act);
        check_count({name, " busy drops"}, 0, busy_err - busy0);
        check_bit({name, " busy"}, 1'b0, busy);
        check_bit({name, " hdr_ready"}, 1'b1, hdr_ready);
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        $display("test %-18s %s", name, (errors == err0) ? "ok" : "has errors");
    endtask

    task automatic test_full_record();
        int err0;
        err0 = errors;
        randomize_fields();
        gen_qp.ack_valid = 1'b1;
        gen_start        = 1'b1;
        gen_dma[1:0]     = 2'b11;
        send_and_check("full_record", `CM_LISTEN_PORT, GOOD_LEN, 2, 0, 1'b1);
        check_bit("full_record loc_qpn", 1'b1, meta_act.loc_qpn == gen_qp.rem_qpn);
        check_bit("full_record dma low bits", 1'b0, |meta_act.dma_length[1:0]);
        end_test("full_record", err0);
    endtask

    task automatic test_bad_header();
        int err0;
        err0 = errors;
        randomize_fields();
        send_and_check("bad_port", 16'h1234, GOOD_LEN, 2, 0, 1'b0);
        randomize_fields();
        send_and_check("bad_length", `CM_LISTEN_PORT, 16'd80, 2, 0, 1'b0);
        randomize_fields();
        send_and_check("after_drop", `CM_LISTEN_PORT, GOOD_LEN, 2, 0, 1'b1);
        end_test("bad_header", err0);
    endtask

    task automatic test_selective_update();
        int err0;
        err0 = errors;
        randomize_fields();
        gen_qp_v = 1'b0;
        send_and_check("meta_only", `CM_LISTEN_PORT, GOOD_LEN, 2, 0, 1'b1);
        randomize_fields();
        gen_tx_v = 1'b0;
        send_and_check("qp_only", `CM_LISTEN_PORT, GOOD_LEN, 2, 0, 1'b1);
        randomize_fields();
        gen_start = 1'b0;
        send_and_check("no_start", `CM_LISTEN_PORT, GOOD_LEN, 2, 0, 1'b1);
        end_test("selective_update", err0);
    endtask

    task automatic test_short_frame();
        int err0;
        err0 = errors;
        randomize_fields();
        send_and_check("short_frame", `CM_LISTEN_PORT, GOOD_LEN, 1, 0, 1'b0);
        end_test("short_frame", err0);
    endtask

    task automatic test_stalled_input();
        int err0;
        err0 = errors;
        for (int k = 0; k < 4; k++) begin
            randomize_fields();
            send_and_check("stalled_input", `CM_LISTEN_PORT, GOOD_LEN, 2, 3, 1'b1);
        end
        end_test("stalled_input", err0);
    endtask

    initial begin
        void'($urandom(32'h6832abfc));
        rst            <= 1'b1;
        hdr_valid      <= 1'b0;
        udp_dest_port  <= '0;
        udp_length     <= '0;
        payload_tdata  <= '0;
        payload_tkeep  <= '0;
        payload_tvalid <= 1'b0;
        payload_tlast  <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_full_record();
        test_bad_header();
        test_selective_update();
        test_short_frame();
        test_stalled_input();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
